//--- bench/sram_model.sv
`timescale 1ns/1ps

module sram_model (
	input  logic [17:0] addr,
	input  logic [15:0] wdata,
	input  logic        cen,
	input  logic        oen,
	input  logic        wen,
	output logic [15:0] rdata
);
	localparam int settle_ns = 2; // inside the one-cycle strobe.

	logic [15:0] mem [2**18];

	function automatic logic [15:0] fill_value(input logic [17:0] a);
		return a[15:0] ^ {a[17:16], 14'h1a5};
	endfunction

	initial begin
		for (int i = 0; i < 2**18; i++)
			mem[i] = fill_value(18'(i));
	end

	// write lands once address and data have settled.
	always @(negedge wen) begin
		#(settle_ns);
		if (!wen && !cen)
			mem[addr] = wdata;
	end

	assign rdata = (!cen && !oen) ? mem[addr] : 16'h0000;

endmodule

//--- bench/tape_subsystem_tb.sv
`timescale 1ns/1ps

module tape_subsystem_tb;
	import tape_pkg::*;

	localparam int bw              = 8;
	localparam int transfer_cycles = 1 + 4 * bw; // start pulse, then four per word.
	localparam int wait_limit      = 200;

	logic        clk = 1'b0;
	logic        reset;
	logic        cmd_valid;
	tape_cmd_t   cmd;
	mem_addr_t   host_addr;
	logic        host_we;
	word_t       host_wdata;
	logic [15:0] sram_rdata;
	word_t       host_rdata;
	logic        cmd_reject;
	logic        busy;
	logic        done;
	block_t      position;
	sram_bus_t   sram;

	logic [15:0] lfsr = 16'd17723;
	word_t       words [bw];
	logic [15:0] saved [2*bw];
	block_t      out_block;
	block_t      expect_pos = '0;
	logic        out_check  = 1'b0;
	int          strobes;

	tape_subsystem #(.block_words(bw)) tape_subsystem_inst (.*);

	sram_model sram_model_inst (
		.addr  (sram.addr),
		.wdata (sram.wdata),
		.cen   (sram.cen),
		.oen   (sram.oen),
		.wen   (sram.wen),
		.rdata (sram_rdata)
	);

	initial begin
		forever #4 clk = ~clk;
	end

	// ----------------------------------------
	task automatic fail_run(input string what);
		$display("%s at %0t", what, $time);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got == exp) else begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	task automatic draw_word(output word_t w);
		for (int i = 0; i < word_bits; i++) begin
			w[i] = lfsr[0]; // one step per bit.
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// low half is bits 15..0, high half is sign and bits 29..16.
	function automatic logic [15:0] half_of(input word_t w, input logic hi);
		return hi ? {1'b0, w[30:16]} : w[15:0];
	endfunction

	task automatic host_write(input mem_addr_t a, input word_t d);
		@(negedge clk);
		host_addr  = a;
		host_wdata = d;
		host_we    = 1'b1;
		@(negedge clk);
		host_we = 1'b0;
	endtask

	task automatic host_read(input mem_addr_t a, output word_t d);
		@(negedge clk);
		host_addr = a;
		@(negedge clk);
		d = host_rdata;
	endtask

	task automatic strobe_cmd(input tape_op_e code, input mem_addr_t a, input logic neg,
			input logic [11:0] mag);
		@(negedge clk);
		cmd_valid = 1'b1;
		cmd       = '{op: code, mem_addr: a, offset_neg: neg, offset_mag: mag};
	endtask

	task automatic ioc(input logic neg, input logic [11:0] mag);
		int p;
		p = int'(expect_pos);
		if (mag == 0)
			p = 0;
		else if (neg)
			p = p - int'(mag);
		else
			p = p + int'(mag);
		expect_pos = block_t'(((p % 1024) + 1024) % 1024);
		strobe_cmd(op_ioc, '0, neg, mag);
		@(negedge clk);
		cmd_valid = 1'b0;
		check_value("cmd_reject", cmd_reject, 0);
		@(negedge clk);
		check_value("position", position, expect_pos);
		check_value("busy", busy, 0);
	endtask

	// inject_at > 0 strobes a second command at that busy cycle.
	task automatic run_transfer(input tape_op_e code, input mem_addr_t a, input int inject_at);
		int n;
		n = 0;
		strobe_cmd(code, a, 1'b0, 12'd0);
		while (done !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > wait_limit)
				fail_run("timeout waiting for done");
			if (n == inject_at)
				cmd = '{op: op_in, mem_addr: 12'hfff, offset_neg: 1'b0, offset_mag: 12'd0};
			cmd_valid = (n == inject_at);
			if (n == 1)
				check_value("cmd_reject", cmd_reject, 0);
			if (inject_at > 0 && n == inject_at + 1)
				check_value("cmd_reject", cmd_reject, 1);
		end
		check_value("done cycle", n, transfer_cycles);
		@(negedge clk);
		check_value("busy", busy, 0);
		check_value("done", done, 0);
		expect_pos = block_t'((int'(expect_pos) + 1) % 1024);
		check_value("position", position, expect_pos);
	endtask

	// ----------------------------------------
	// checkers
	always @(negedge clk) begin : layout_check
		int k;
		if (out_check && !sram.wen) begin
			k = int'(sram.addr[7:0]) / 2;
			check_value("sram.addr[17:8]", sram.addr[17:8], out_block);
			if (k >= bw)
				fail_run("write strobe beyond the end of the block");
			check_value("sram.wdata", sram.wdata, half_of(words[k], sram.addr[0]));
			strobes++;
		end
	end

	a_busy_falls: assert property (@(posedge clk) disable iff (reset) done |=> !busy)
		else fail_run("busy still high after the done pulse");

	a_idle_bus: assert property (@(posedge clk) disable iff (reset)
		!busy |-> sram.cen && sram.oen && sram.wen && !sram.drive)
		else fail_run("sram controls active while idle");

	// ----------------------------------------
	initial begin
		word_t got;
		reset      = 1'b1;
		cmd_valid  = 1'b0;
		cmd        = '0;
		host_addr  = '0;
		host_we    = 1'b0;
		host_wdata = '0;
		repeat (16) @(negedge clk);
		check_value("busy", busy, 0);
		check_value("done", done, 0);
		check_value("cmd_reject", cmd_reject, 0);
		check_value("sram.cen", sram.cen, 1);
		check_value("sram.oen", sram.oen, 1);
		check_value("sram.wen", sram.wen, 1);
		check_value("sram.drive", sram.drive, 0);
		check_value("position", position, 0);
		reset = 1'b0;

		// round trip through block 0.
		for (int i = 0; i < bw; i++) begin
			draw_word(words[i]);
			host_write(mem_addr_t'(12'h100 + i), words[i]);
		end
		out_block = expect_pos;
		strobes   = 0;
		out_check = 1'b1;
		run_transfer(op_out, 12'h100, 0);
		out_check = 1'b0;
		check_value("write strobes", strobes, 2 * bw);
		ioc(1'b0, 12'd0); // rewind.
		run_transfer(op_in, 12'h300, 0);
		for (int i = 0; i < bw; i++) begin
			host_read(mem_addr_t'(12'h300 + i), got);
			check_value("host_rdata", got, words[i]);
		end

		ioc(1'b0, 12'd5);
		ioc(1'b1, 12'd3);
		ioc(1'b1, 12'd1);
		ioc(1'b1, 12'd10); // wraps below zero.

		// rejected command during an accepted transfer.
		for (int i = 0; i < bw; i++) begin
			draw_word(words[i]);
			host_write(mem_addr_t'(12'h100 + i), words[i]);
		end
		out_block = expect_pos;
		for (int i = 0; i < 2 * bw; i++)
			saved[i] = sram_model_inst.mem[{block_t'(out_block + 1), 8'(i)}];
		strobes   = 0;
		out_check = 1'b1;
		run_transfer(op_out, 12'h100, 10);
		out_check = 1'b0;
		check_value("write strobes", strobes, 2 * bw);
		for (int i = 0; i < 2 * bw; i++) begin
			check_value("sram slot", sram_model_inst.mem[{out_block, 8'(i)}],
				half_of(words[i / 2], i[0]));
			check_value("next slot", sram_model_inst.mem[{block_t'(out_block + 1), 8'(i)}],
				saved[i]);
		end
		repeat (4) @(negedge clk);
		check_value("busy", busy, 0);
		check_value("position", position, expect_pos);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- filelist.f
src/tape_pkg.sv
src/tape_cmd_regs.sv
src/tape_transfer.sv
src/word_memory.sv
src/tape_subsystem.sv
bench/sram_model.sv
bench/tape_subsystem_tb.sv

//--- run_sim.sh
#!/bin/sh
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tape_subsystem_tb \
	-Mdir obj_dir \
	-o tape_subsystem_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/tape_subsystem_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi
exit 0

//--- src/tape_cmd_regs.sv
`timescale 1ns/1ps

module tape_cmd_regs (
	input  logic                clk,
	input  logic                reset,
	input  logic                cmd_valid,
	input  tape_pkg::tape_cmd_t cmd,
	input  logic                busy,
	output logic                cmd_reject,
	output logic                start_write,
	output logic                start_read,
	output logic                seek,
	output logic                seek_neg,
	output logic [11:0]         seek_mag,
	output tape_pkg::mem_addr_t start_addr
);
	import tape_pkg::*;

	cmd_state_e state;
	tape_cmd_t  held;
	logic       accept;

	// a command is taken only from idle with the engine quiet.
	assign accept = cmd_valid & ~busy & (state == st_idle);

	always_ff @(posedge clk) begin
		if (reset) begin
			state      <= st_idle;
			cmd_reject <= 1'b0;
		end else begin
			cmd_reject <= cmd_valid & ~accept;
			case (state)
				st_idle:
					if (accept)
						state <= st_issue;
				default:
					state <= st_idle; // one issue cycle only.
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			held <= cmd;
	end

	// ----------------------------------------
	// decode
	always_comb begin
		start_write = 1'b0;
		start_read  = 1'b0;
		seek        = 1'b0;
		if (state == st_issue) begin
			case (held.op)
				op_out:  start_write = 1'b1;
				op_in:   start_read  = 1'b1;
				op_ioc:  seek        = 1'b1;
				default: seek        = 1'b0; // unused code, no pulse.
			endcase
		end
	end

	assign seek_neg   = held.offset_neg;
	assign seek_mag   = held.offset_mag;
	assign start_addr = held.mem_addr;

	// ----------------------------------------
	// checks
	a_quiet_when_busy: assert property (@(posedge clk) disable iff (reset)
		busy |-> !(start_write || start_read || seek));

endmodule

//--- src/tape_pkg.sv
package tape_pkg;

	// ----------------------------------------
	// widths
	localparam int word_bits      = 31;
	localparam int mem_addr_bits  = 12;
	localparam int block_bits     = 10;
	localparam int sram_addr_bits = 18;
	localparam int half_bits      = 16;
	localparam int slot_halfwords = 256; // halfwords owned by one block.

	typedef logic [word_bits-1:0]      word_t;      // sign in bit 30.
	typedef logic [mem_addr_bits-1:0]  mem_addr_t;
	typedef logic [block_bits-1:0]     block_t;
	typedef logic [sram_addr_bits-1:0] sram_addr_t;

	// ----------------------------------------
	// commands
	typedef enum logic [1:0] {
		op_ioc = 2'd0,
		op_in  = 2'd1,
		op_out = 2'd2
	} tape_op_e;

	typedef enum logic {
		st_idle,
		st_issue
	} cmd_state_e;

	typedef struct packed {
		tape_op_e    op;
		mem_addr_t   mem_addr;   // core start for in and out.
		logic        offset_neg;
		logic [11:0] offset_mag; // ioc step, zero rewinds.
	} tape_cmd_t;

	// ----------------------------------------
	// sram side, controls active low
	typedef struct packed {
		sram_addr_t           addr;
		logic [half_bits-1:0] wdata;
		logic                 drive; // pad enable, outside the top.
		logic                 cen;
		logic                 oen;
		logic                 wen;
	} sram_bus_t;

endpackage

//--- src/tape_subsystem.sv
`timescale 1ns/1ps

module tape_subsystem #(
	parameter int block_words = 100
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                cmd_valid,
	input  tape_pkg::tape_cmd_t cmd,
	input  tape_pkg::mem_addr_t host_addr,
	input  logic                host_we,
	input  tape_pkg::word_t     host_wdata,
	input  logic [15:0]         sram_rdata,
	output tape_pkg::word_t     host_rdata,
	output logic                cmd_reject,
	output logic                busy,
	output logic                done,
	output tape_pkg::block_t    position,
	output tape_pkg::sram_bus_t sram
);
	import tape_pkg::*;

	logic        start_write;
	logic        start_read;
	logic        seek;
	logic        seek_neg;
	logic [11:0] seek_mag;
	mem_addr_t   start_addr;
	mem_addr_t   mem_addr;
	logic        mem_rd;
	logic        mem_we;
	word_t       mem_wdata;
	word_t       mem_rdata;

	tape_cmd_regs tape_cmd_regs_inst (
		.clk         (clk),
		.reset       (reset),
		.cmd_valid   (cmd_valid),
		.cmd         (cmd),
		.busy        (busy),
		.cmd_reject  (cmd_reject),
		.start_write (start_write),
		.start_read  (start_read),
		.seek        (seek),
		.seek_neg    (seek_neg),
		.seek_mag    (seek_mag),
		.start_addr  (start_addr)
	);

	tape_transfer #(
		.block_words (block_words)
	) tape_transfer_inst (
		.clk         (clk),
		.reset       (reset),
		.start_write (start_write),
		.start_read  (start_read),
		.start_addr  (start_addr),
		.seek        (seek),
		.seek_neg    (seek_neg),
		.seek_mag    (seek_mag),
		.mem_rdata   (mem_rdata),
		.sram_rdata  (sram_rdata),
		.busy        (busy),
		.done        (done),
		.position    (position),
		.mem_addr    (mem_addr),
		.mem_rd      (mem_rd),
		.mem_we      (mem_we),
		.mem_wdata   (mem_wdata),
		.sram        (sram)
	);

	word_memory word_memory_inst (
		.clk     (clk),
		.a_addr  (mem_addr),
		.a_rd    (mem_rd),
		.a_we    (mem_we),
		.a_wdata (mem_wdata),
		.b_addr  (host_addr),
		.b_we    (host_we),
		.b_wdata (host_wdata),
		.a_rdata (mem_rdata),
		.b_rdata (host_rdata)
	);

endmodule

//--- src/tape_transfer.sv
`timescale 1ns/1ps

module tape_transfer #(
	parameter int block_words = 100
) (
	input  logic                clk,
	input  logic                reset,
	input  logic                start_write,
	input  logic                start_read,
	input  tape_pkg::mem_addr_t start_addr,
	input  logic                seek,
	input  logic                seek_neg,
	input  logic [11:0]         seek_mag,
	input  tape_pkg::word_t     mem_rdata,
	input  logic [15:0]         sram_rdata,
	output logic                busy,
	output logic                done,
	output tape_pkg::block_t    position,
	output tape_pkg::mem_addr_t mem_addr,
	output logic                mem_rd,
	output logic                mem_we,
	output tape_pkg::word_t     mem_wdata,
	output tape_pkg::sram_bus_t sram
);
	import tape_pkg::*;

	localparam logic [7:0] last_half = 8'(2 * block_words - 1);

	if (2 * block_words > slot_halfwords) begin : g_size_check
		$error("block_words does not fit one slot");
	end

	logic                 write_mode;
	logic                 read_mode;
	logic [1:0]           phase;
	sram_addr_t           half_addr;
	mem_addr_t            core_addr;
	word_t                hold;
	logic                 wen_q;
	logic                 we_q;
	logic                 last;
	logic [half_bits-1:0] wdata;

	assign busy = write_mode | read_mode;
	assign last = busy && (phase == 2'd3) && (half_addr[7:0] == last_half);
	assign done = last;

	// ----------------------------------------
	// block position
	always_ff @(posedge clk) begin
		if (reset)
			position <= '0;
		else if (seek && seek_mag == '0)
			position <= '0; // rewind.
		else if (seek && seek_neg)
			position <= position - block_t'(seek_mag);
		else if (seek)
			position <= position + block_t'(seek_mag);
		else if (done)
			position <= position + 1'b1;
	end

	// ----------------------------------------
	// mode flags and phase
	always_ff @(posedge clk) begin
		if (reset) begin
			write_mode <= 1'b0;
			read_mode  <= 1'b0;
			phase      <= 2'd0;
			wen_q      <= 1'b1;
			we_q       <= 1'b0;
		end else begin
			if (start_write)
				write_mode <= 1'b1;
			else if (last)
				write_mode <= 1'b0;

			if (start_read)
				read_mode <= 1'b1;
			else if (last)
				read_mode <= 1'b0;

			if (start_write || start_read)
				phase <= 2'd0;
			else if (busy)
				phase <= phase + 2'd1;

			// strobe low in the even phases that follow.
			wen_q <= ~(start_write | (write_mode & phase[0] & ~last));
			we_q  <= read_mode & (phase == 2'd2);
		end
	end

	// ----------------------------------------
	// addresses
	always_ff @(posedge clk) begin
		if (start_write || start_read) begin
			half_addr <= sram_addr_t'(position) * sram_addr_t'(slot_halfwords);
			core_addr <= start_addr;
		end else begin
			if (busy && phase[0] && !last)
				half_addr <= half_addr + 1'b1; // after phases 1 and 3.
			if ((write_mode && phase == 2'd2) || (read_mode && phase == 2'd3))
				core_addr <= core_addr + 1'b1;
		end
	end

	// word held for the high half on write, assembled on read.
	always_ff @(posedge clk) begin
		if (write_mode && phase == 2'd0)
			hold <= mem_rdata;
		else if (read_mode && phase == 2'd0)
			hold[15:0] <= sram_rdata;
		else if (read_mode && phase == 2'd2)
			hold[30:16] <= sram_rdata[14:0];
	end

	// next core word arrives for phase 0.
	assign mem_rd    = start_write | (write_mode & (phase == 2'd3) & ~last);
	assign mem_addr  = start_write ? start_addr : core_addr;
	assign mem_we    = we_q;
	assign mem_wdata = hold;

	always_comb begin
		case (phase)
			2'd0:    wdata = mem_rdata[15:0];
			2'd1:    wdata = hold[15:0];
			default: wdata = {1'b0, hold[30:16]}; // sign and bits 29..16.
		endcase
	end

	always_comb begin
		sram.addr  = half_addr;
		sram.wdata = wdata;
		sram.drive = write_mode;
		sram.cen   = ~busy;
		sram.oen   = ~read_mode;
		sram.wen   = wen_q;
	end

	// ----------------------------------------
	// checks
	a_wen_strobe: assert property (@(posedge clk) disable iff (reset)
		!sram.wen |-> write_mode ##1 sram.wen);

	a_drive_write: assert property (@(posedge clk) disable iff (reset)
		sram.drive |-> write_mode && sram.oen);

	a_in_slot: assert property (@(posedge clk) disable iff (reset)
		busy |-> half_addr[17:8] == position);

endmodule

//--- src/word_memory.sv
`timescale 1ns/1ps

module word_memory (
	input  logic                clk,
	input  tape_pkg::mem_addr_t a_addr,
	input  logic                a_rd,
	input  logic                a_we,
	input  tape_pkg::word_t     a_wdata,
	input  tape_pkg::mem_addr_t b_addr,
	input  logic                b_we,
	input  tape_pkg::word_t     b_wdata,
	output tape_pkg::word_t     a_rdata,
	output tape_pkg::word_t     b_rdata
);
	import tape_pkg::*;

	localparam int depth = 2 ** mem_addr_bits;

	word_t core [depth];

	// ----------------------------------------
	// port a is the tape, port b the host
	always_ff @(posedge clk) begin
		if (a_we)
			core[a_addr] <= a_wdata;
		if (b_we)
			core[b_addr] <= b_wdata;
	end

	// tape read data holds until the next read.
	always_ff @(posedge clk) begin
		if (a_rd)
			a_rdata <= core[a_addr];
	end

	always_ff @(posedge clk) begin
		b_rdata <= core[b_addr];
	end

	// host stays off the tape's words.
	a_no_collide: assert property (@(posedge clk)
		(a_we && b_we) |-> a_addr != b_addr);

endmodule
